//--- compile.f
csr_pkg.sv
csr_decode.sv
csr_exec.sv
csr_trap.sv
csr_file.sv
csr_result.sv
csr_unit.sv
tb_csr_unit.sv

//--- csr_decode.sv
// csr_decode: registered decode of SYSTEM instructions into a CSR operation record
module csr_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_valid,
  input  logic [31:0]              i_instr,
  input  logic [csr_pkg::XLEN-1:0] i_rs1_data,
  input  logic [csr_pkg::XLEN-1:0] i_pc,
  output csr_pkg::csr_op_t         o_op
);

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [2:0]         funct3;
  logic               is_system;
  csr_pkg::csr_kind_e kind_d;

  assign funct3    = i_instr[14:12];
  assign is_system = (i_instr[6:0] == OPC_SYSTEM);

  always_comb begin
    kind_d = csr_pkg::NONE;
    if (is_system) begin
      case (funct3)
        3'b001, 3'b101: kind_d = csr_pkg::CSRRW;
        3'b010, 3'b110: kind_d = csr_pkg::CSRRS;
        3'b011, 3'b111: kind_d = csr_pkg::CSRRC;
        3'b000: begin
          if (i_instr[31:7] == 25'h0) begin
            kind_d = csr_pkg::ECALL;
          end else if (i_instr[31:20] == 12'h302 && i_instr[19:7] == 13'h0) begin
            kind_d = csr_pkg::MRET;
          end
        end
        default: ; // other encodings pass as bubbles
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_op.valid <= 1'b0;
    end else begin
      o_op.valid <= i_valid;
    end
    o_op.kind     <= kind_d;
    o_op.addr     <= i_instr[31:20];
    o_op.rd       <= i_instr[11:7];
    o_op.src      <= funct3[2] ? {{(csr_pkg::XLEN-5){1'b0}}, i_instr[19:15]} : i_rs1_data;
    o_op.src_zero <= (i_instr[19:15] == 5'd0); // rs1 index or zimm
    o_op.pc       <= i_pc;
  end

  // funct3 of zero is the ecall/mret space, never a CSR access
  a_no_csr_f3_zero: assert property (@(posedge clk) disable iff (rst)
    (i_valid && funct3 == 3'b000) |=>
      !(o_op.kind inside {csr_pkg::CSRRW, csr_pkg::CSRRS, csr_pkg::CSRRC}));

endmodule

//--- csr_exec.sv
// csr_exec: CSR read-modify-write value and rd data for the op in execute
module csr_exec (
  input  csr_pkg::csr_op_t         i_op,
  input  logic [csr_pkg::XLEN-1:0] i_rdata,
  output logic [11:0]              o_raddr,
  output csr_pkg::csr_wr_t         o_wr,
  output csr_pkg::result_t         o_res
);

  logic                     is_csr;
  logic [csr_pkg::XLEN-1:0] new_val;
  logic                     wr_req;

  assign o_raddr = i_op.addr;

  assign is_csr = i_op.kind inside {csr_pkg::CSRRW, csr_pkg::CSRRS, csr_pkg::CSRRC};

  always_comb begin
    new_val = i_op.src;
    wr_req  = 1'b0;
    case (i_op.kind)
      csr_pkg::CSRRW: begin
        new_val = i_op.src; // swap
        wr_req  = 1'b1;
      end
      csr_pkg::CSRRS: begin
        new_val = i_rdata | i_op.src;
        wr_req  = !i_op.src_zero; // x0 source reads only
      end
      csr_pkg::CSRRC: begin
        new_val = i_rdata & ~i_op.src;
        wr_req  = !i_op.src_zero;
      end
      default: ;
    endcase
  end

  always_comb begin
    o_wr.en   = i_op.valid && wr_req;
    o_wr.addr = i_op.addr;
    o_wr.data = new_val;
  end

  // redirect comes from the trap path only
  always_comb begin
    o_res.rd_we       = i_op.valid && is_csr && (i_op.rd != 5'd0);
    o_res.rd_addr     = i_op.rd;
    o_res.rd_data     = i_rdata; // old value
    o_res.redirect    = 1'b0;
    o_res.redirect_pc = '0;
  end

endmodule

//--- csr_file.sv
// csr_file: machine-mode CSR storage with read mux, write port, trap update and cycle counter
module csr_file (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [11:0]              i_raddr,
  input  csr_pkg::csr_wr_t         i_wr,
  input  csr_pkg::trap_upd_t       i_trap,
  input  logic                     i_irq_timer,
  output logic [csr_pkg::XLEN-1:0] o_rdata,
  output logic [csr_pkg::XLEN-1:0] o_mstatus,
  output logic [csr_pkg::XLEN-1:0] o_mie,
  output logic [csr_pkg::XLEN-1:0] o_mtvec,
  output logic [csr_pkg::XLEN-1:0] o_mepc
);

  logic [csr_pkg::XLEN-1:0] mcycle;
  logic [csr_pkg::XLEN-1:0] mstatus;
  logic [csr_pkg::XLEN-1:0] mie;
  logic [csr_pkg::XLEN-1:0] mtvec;
  logic [csr_pkg::XLEN-1:0] mscratch;
  logic [csr_pkg::XLEN-1:0] mepc;
  logic [csr_pkg::XLEN-1:0] mcause;
  logic [csr_pkg::XLEN-1:0] mip;
  logic                     wr_sd;

  // mip is not stored, MTIP mirrors the timer level
  always_comb begin
    mip = '0;
    mip[csr_pkg::MIE_MTIE_BIT] = i_irq_timer;
  end

  // SD summarizes dirty FS or XS
  assign wr_sd = (i_wr.data[14:13] == 2'b11) | (i_wr.data[16:15] == 2'b11);

  always_comb begin
    case (i_raddr)
      csr_pkg::CSR_MCYCLE:   o_rdata = mcycle;
      csr_pkg::CSR_MSTATUS:  o_rdata = mstatus;
      csr_pkg::CSR_MIE:      o_rdata = mie;
      csr_pkg::CSR_MTVEC:    o_rdata = mtvec;
      csr_pkg::CSR_MSCRATCH: o_rdata = mscratch;
      csr_pkg::CSR_MEPC:     o_rdata = mepc;
      csr_pkg::CSR_MCAUSE:   o_rdata = mcause;
      csr_pkg::CSR_MIP:      o_rdata = mip;
      default:               o_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle   <= '0;
      mstatus  <= csr_pkg::MSTATUS_RESET;
      mie      <= '0;
      mtvec    <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else begin
      mcycle <= mcycle + 64'd1; // free running
      if (i_trap.take) begin
        mstatus <= i_trap.mstatus;
        if (!i_trap.is_mret) begin
          mepc   <= i_trap.mepc;
          mcause <= i_trap.mcause;
        end
      end else if (i_wr.en) begin
        case (i_wr.addr)
          csr_pkg::CSR_MSTATUS:  mstatus  <= {wr_sd, i_wr.data[62:0]};
          csr_pkg::CSR_MIE:      mie      <= i_wr.data;
          csr_pkg::CSR_MTVEC:    mtvec    <= i_wr.data;
          csr_pkg::CSR_MSCRATCH: mscratch <= i_wr.data;
          csr_pkg::CSR_MEPC:     mepc     <= i_wr.data;
          csr_pkg::CSR_MCAUSE:   mcause   <= i_wr.data;
          default: ; // mcycle, mip and unknown ignore writes
        endcase
      end
    end
  end

  assign o_mstatus = mstatus;
  assign o_mie     = mie;
  assign o_mtvec   = mtvec;
  assign o_mepc    = mepc;

  a_mcycle_step: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> mcycle == $past(mcycle) + 64'd1);

  // holds through CSR writes and trap updates alike
  a_mstatus_sd: assert property (@(posedge clk) disable iff (rst)
    mstatus[63] == ((mstatus[14:13] == 2'b11) | (mstatus[16:15] == 2'b11)));

endmodule

//--- csr_pkg.sv
// csr_pkg: shared widths, CSR addresses, reset values and stage records for the CSR unit
package csr_pkg;

  localparam int XLEN = 64;

  // machine CSR addresses
  localparam logic [11:0] CSR_MCYCLE   = 12'hB00;
  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MIE      = 12'h304;
  localparam logic [11:0] CSR_MTVEC    = 12'h305;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_MIP      = 12'h344;

  localparam logic [XLEN-1:0] MSTATUS_RESET = 64'h1800; // MPP = M

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;
  localparam logic [XLEN-1:0] CAUSE_MTI     = 64'h8000_0000_0000_0007;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MIE_MTIE_BIT     = 7; // mip.MTIP uses the same index

  typedef enum logic [2:0] {
    NONE  = 3'd0,
    CSRRW = 3'd1,
    CSRRS = 3'd2,
    CSRRC = 3'd3,
    ECALL = 3'd4,
    MRET  = 3'd5
  } csr_kind_e;

  typedef struct packed {
    logic            valid;
    csr_kind_e       kind;
    logic [11:0]     addr;
    logic [4:0]      rd;
    logic [XLEN-1:0] src;      // rs1 value or zimm
    logic            src_zero;
    logic [XLEN-1:0] pc;
  } csr_op_t;

  typedef struct packed {
    logic            en;
    logic [11:0]     addr;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic            take;
    logic            is_mret;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] target;
  } trap_upd_t;

  typedef struct packed {
    logic            rd_we;
    logic [4:0]      rd_addr;
    logic [XLEN-1:0] rd_data;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
  } result_t;

endpackage

//--- csr_result.sv
// csr_result: result register merging execute outcome with trap redirect
module csr_result (
  input  logic               clk,
  input  logic               rst,
  input  csr_pkg::result_t   i_res,
  input  csr_pkg::trap_upd_t i_trap,
  output csr_pkg::result_t   o_res
);

  csr_pkg::result_t res_d;

  always_comb begin
    res_d = i_res;
    if (i_trap.take) begin
      res_d.rd_we       = 1'b0; // trapped op retires nothing
      res_d.redirect    = 1'b1;
      res_d.redirect_pc = i_trap.target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_res.rd_we    <= 1'b0;
      o_res.redirect <= 1'b0;
    end else begin
      o_res.rd_we    <= res_d.rd_we;
      o_res.redirect <= res_d.redirect;
    end
    o_res.rd_addr     <= res_d.rd_addr;
    o_res.rd_data     <= res_d.rd_data;
    o_res.redirect_pc <= res_d.redirect_pc;
  end

  a_we_xor_redirect: assert property (@(posedge clk) disable iff (rst)
    !(o_res.rd_we && o_res.redirect));

endmodule

//--- csr_trap.sv
// csr_trap: picks timer interrupt, ecall or mret and builds the trap register update
module csr_trap (
  input  csr_pkg::csr_op_t         i_op,
  input  logic                     i_irq_timer,
  input  logic [csr_pkg::XLEN-1:0] i_mstatus,
  input  logic [csr_pkg::XLEN-1:0] i_mie,
  input  logic [csr_pkg::XLEN-1:0] i_mtvec,
  input  logic [csr_pkg::XLEN-1:0] i_mepc,
  output csr_pkg::trap_upd_t       o_trap
);

  logic                     irq;
  logic                     ecall;
  logic                     mret;
  logic                     do_mret;
  logic [csr_pkg::XLEN-1:0] mstatus_d;

  // interrupt needs global enable, timer enable and pending level
  assign irq = i_op.valid
            && i_mstatus[csr_pkg::MSTATUS_MIE_BIT]
            && i_mie[csr_pkg::MIE_MTIE_BIT]
            && i_irq_timer;

  assign ecall   = i_op.valid && (i_op.kind == csr_pkg::ECALL);
  assign mret    = i_op.valid && (i_op.kind == csr_pkg::MRET);
  assign do_mret = mret && !irq; // interrupt wins

  always_comb begin
    mstatus_d = i_mstatus;
    if (do_mret) begin
      mstatus_d[csr_pkg::MSTATUS_MIE_BIT]  = i_mstatus[csr_pkg::MSTATUS_MPIE_BIT];
      mstatus_d[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    end else begin
      mstatus_d[csr_pkg::MSTATUS_MPIE_BIT] = i_mstatus[csr_pkg::MSTATUS_MIE_BIT];
      mstatus_d[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
    end
  end

  always_comb begin
    o_trap.take    = irq || ecall || mret;
    o_trap.is_mret = do_mret;
    o_trap.mepc    = i_op.pc; // interrupted or faulting pc
    o_trap.mcause  = irq ? csr_pkg::CAUSE_MTI : csr_pkg::CAUSE_ECALL_M;
    o_trap.mstatus = mstatus_d;
    if (do_mret) begin
      o_trap.target = i_mepc;
    end else begin
      o_trap.target = {i_mtvec[csr_pkg::XLEN-1:2], 2'b00}; // direct mode only
    end
  end

endmodule

//--- csr_unit.sv
// csr_unit: machine-mode CSR unit with decode, execute, trap and result stages
module csr_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_valid,
  input  logic [31:0]              i_instr,
  input  logic [csr_pkg::XLEN-1:0] i_rs1_data,
  input  logic [csr_pkg::XLEN-1:0] i_pc,
  input  logic                     i_irq_timer,
  output logic                     o_rd_we,
  output logic [4:0]               o_rd_addr,
  output logic [csr_pkg::XLEN-1:0] o_rd_data,
  output logic                     o_redirect,
  output logic [csr_pkg::XLEN-1:0] o_redirect_pc
);

  csr_pkg::csr_op_t         op;
  csr_pkg::csr_wr_t         wr;
  csr_pkg::trap_upd_t       trap;
  csr_pkg::result_t         ex_res;
  csr_pkg::result_t         res;
  logic [11:0]              raddr;
  logic [csr_pkg::XLEN-1:0] rdata;
  logic [csr_pkg::XLEN-1:0] mstatus;
  logic [csr_pkg::XLEN-1:0] mie;
  logic [csr_pkg::XLEN-1:0] mtvec;
  logic [csr_pkg::XLEN-1:0] mepc;

  csr_decode u_decode (.clk, .rst, .i_valid, .i_instr, .i_rs1_data, .i_pc, .o_op(op));

  csr_exec u_exec (.i_op(op), .i_rdata(rdata), .o_raddr(raddr), .o_wr(wr), .o_res(ex_res));

  csr_trap u_trap (
    .i_op(op), .i_irq_timer, .i_mstatus(mstatus), .i_mie(mie),
    .i_mtvec(mtvec), .i_mepc(mepc), .o_trap(trap)
  );

  csr_file u_file (
    .clk, .rst, .i_raddr(raddr), .i_wr(wr), .i_trap(trap), .i_irq_timer,
    .o_rdata(rdata), .o_mstatus(mstatus), .o_mie(mie), .o_mtvec(mtvec), .o_mepc(mepc)
  );

  csr_result u_result (.clk, .rst, .i_res(ex_res), .i_trap(trap), .o_res(res));

  assign o_rd_we       = res.rd_we;
  assign o_rd_addr     = res.rd_addr;
  assign o_rd_data     = res.rd_data;
  assign o_redirect    = res.redirect;
  assign o_redirect_pc = res.redirect_pc;

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_csr_unit -f compile.f -o sim_csr_unit
output="$(./obj_dir/sim_csr_unit)"
echo "$output"
if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

//--- tb_csr_unit.sv
// tb_csr_unit: checks the CSR unit against a CSR register model with directed and random ops
module tb_csr_unit;

  localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;
  localparam logic [31:0] INSTR_MRET  = 32'h3020_0073;
  localparam logic [31:0] INSTR_NOP   = 32'h0000_0013; // addi x0, x0, 0

  typedef struct packed {
    logic [31:0] tag; // cycle count when the result register holds it
    logic        we;
    logic [4:0]  addr;
    logic [63:0] data;
    logic        redirect;
    logic [63:0] pc;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        i_valid;
  logic [31:0] i_instr;
  logic [63:0] i_rs1_data;
  logic [63:0] i_pc;
  logic        i_irq_timer;
  logic        o_rd_we;
  logic [4:0]  o_rd_addr;
  logic [63:0] o_rd_data;
  logic        o_redirect;
  logic [63:0] o_redirect_pc;

  logic [31:0] cyc;
  expect_t     exp_q[$];
  expect_t     exp_now;
  int          head;
  int          fails = 0;
  int          t_fails;
  int          t_checks;
  logic        timed_out;

  // CSR register model
  logic [63:0] m_mstatus;
  logic [63:0] m_mie;
  logic [63:0] m_mtvec;
  logic [63:0] m_mscratch;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic        m_timer;

  csr_unit u_csr_unit (.clk, .rst, .i_valid, .i_instr, .i_rs1_data, .i_pc, .i_irq_timer,
    .o_rd_we, .o_rd_addr, .o_rd_data, .o_redirect, .o_redirect_pc);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    if (rst) begin
      cyc <= '0;
    end else begin
      cyc <= cyc + 32'd1; // cycles since reset ended
    end
  end

  // loads the expectation due this cycle or an idle one
  always @(posedge clk) begin
    if (rst) begin
      exp_now <= '0;
      head    <= 0;
    end else if (head < exp_q.size() && exp_q[head].tag == cyc) begin
      exp_now <= exp_q[head];
      head    <= head + 1;
    end else begin
      exp_now <= '0;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
    $display("Mismatch %s: got %h expected %h", name, got, want);
    fails++;
  endtask

  a_rd_we: assert property (@(posedge clk) disable iff (rst) o_rd_we == exp_now.we)
    else report_mismatch("o_rd_we", 64'($sampled(o_rd_we)), 64'($sampled(exp_now.we)));
  a_redirect: assert property (@(posedge clk) disable iff (rst) o_redirect == exp_now.redirect)
    else report_mismatch("o_redirect", 64'($sampled(o_redirect)),
                         64'($sampled(exp_now.redirect)));
  a_rd_addr: assert property (@(posedge clk) disable iff (rst)
    exp_now.we |-> o_rd_addr == exp_now.addr)
    else report_mismatch("o_rd_addr", 64'($sampled(o_rd_addr)), 64'($sampled(exp_now.addr)));
  a_rd_data: assert property (@(posedge clk) disable iff (rst)
    exp_now.we |-> o_rd_data == exp_now.data)
    else report_mismatch("o_rd_data", $sampled(o_rd_data), $sampled(exp_now.data));
  a_redirect_pc: assert property (@(posedge clk) disable iff (rst)
    exp_now.redirect |-> o_redirect_pc == exp_now.pc)
    else report_mismatch("o_redirect_pc", $sampled(o_redirect_pc), $sampled(exp_now.pc));

  function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                            input logic [4:0] rs1, input logic [4:0] rd);
    return {addr, rs1, f3, rd, 7'h73};
  endfunction

  function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  function automatic logic [11:0] pick_rmw_addr();
    case ($urandom_range(3, 0))
      0: return csr_pkg::CSR_MSCRATCH;
      1: return csr_pkg::CSR_MTVEC;
      2: return csr_pkg::CSR_MIE;
      default: return csr_pkg::CSR_MCYCLE;
    endcase
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] addr, input logic [31:0] now);
    case (addr)
      csr_pkg::CSR_MCYCLE:   return {32'd0, now} + 64'd2; // counted up to the execute cycle
      csr_pkg::CSR_MSTATUS:  return m_mstatus;
      csr_pkg::CSR_MIE:      return m_mie;
      csr_pkg::CSR_MTVEC:    return m_mtvec;
      csr_pkg::CSR_MSCRATCH: return m_mscratch;
      csr_pkg::CSR_MEPC:     return m_mepc;
      csr_pkg::CSR_MCAUSE:   return m_mcause;
      csr_pkg::CSR_MIP:      return {56'd0, m_timer, 7'd0};
      default:               return '0;
    endcase
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [63:0] v);
    case (addr)
      csr_pkg::CSR_MSTATUS:  m_mstatus = {(v[14:13] == 2'b11) || (v[16:15] == 2'b11), v[62:0]};
      csr_pkg::CSR_MIE:      m_mie = v;
      csr_pkg::CSR_MTVEC:    m_mtvec = v;
      csr_pkg::CSR_MSCRATCH: m_mscratch = v;
      csr_pkg::CSR_MEPC:     m_mepc = v;
      csr_pkg::CSR_MCAUSE:   m_mcause = v;
      default: ;
    endcase
  endtask

  task automatic model_issue(input logic [31:0] instr, input logic [63:0] rs1,
                             input logic [63:0] pc, input logic [31:0] now, output expect_t e);
    logic [2:0]  f3;
    logic [11:0] addr;
    logic [63:0] old;
    logic [63:0] src;
    logic        irq;
    f3    = instr[14:12];
    addr  = instr[31:20];
    irq   = m_mstatus[3] && m_mie[7] && m_timer;
    e     = '0;
    e.tag = now + 32'd2;
    if (irq || instr == INSTR_ECALL) begin
      m_mepc       = pc;
      m_mcause     = irq ? csr_pkg::CAUSE_MTI : csr_pkg::CAUSE_ECALL_M;
      m_mstatus[7] = m_mstatus[3]; // MPIE keeps old MIE
      m_mstatus[3] = 1'b0;
      e.redirect   = 1'b1;
      e.pc         = {m_mtvec[63:2], 2'b00};
    end else if (instr == INSTR_MRET) begin
      m_mstatus[3] = m_mstatus[7];
      m_mstatus[7] = 1'b1;
      e.redirect   = 1'b1;
      e.pc         = m_mepc;
    end else if (instr[6:0] == 7'h73 && f3[1:0] != 2'b00) begin
      old    = model_read(addr, now);
      src    = f3[2] ? {59'd0, instr[19:15]} : rs1;
      e.we   = (instr[11:7] != 5'd0);
      e.addr = instr[11:7];
      e.data = old;
      if (f3[1:0] == 2'b01) begin
        model_write(addr, src);
      end else if (instr[19:15] != 5'd0) begin
        model_write(addr, (f3[1:0] == 2'b10) ? (old | src) : (old & ~src));
      end
    end
  endtask

  task automatic issue(input logic [31:0] instr, input logic [63:0] rs1, input logic [63:0] pc);
    expect_t e;
    @(posedge clk);
    model_issue(instr, rs1, pc, cyc, e);
    exp_q.push_back(e);
    i_valid    <= 1'b1;
    i_instr    <= instr;
    i_rs1_data <= rs1;
    i_pc       <= pc;
  endtask

  task automatic idle();
    @(posedge clk);
    i_valid <= 1'b0;
  endtask

  task automatic set_timer(input logic level);
    @(posedge clk);
    i_irq_timer <= level;
    m_timer = level;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle();
    while (head != exp_q.size() && waited < 20) begin
      idle();
      waited++;
    end
    if (head != exp_q.size()) begin
      $display("timeout: %0d expected results never reached the outputs", exp_q.size() - head);
      timed_out = 1'b1;
    end else begin
      repeat (3) idle(); // let the last comparisons fire
    end
  endtask

  task automatic begin_test();
    t_fails  = fails;
    t_checks = head;
  endtask

  task automatic end_test(input string name);
    drain();
    $display("test %s: %s, %0d results checked", name,
             (fails == t_fails && !timed_out) ? "ok" : "failed", head - t_checks);
  endtask

  // stops early once results no longer arrive
  task automatic run_tests();
    logic [11:0] rst_addrs [8] = '{csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MIE, csr_pkg::CSR_MTVEC,
      csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MIP, 12'h7c0};
    logic [63:0] v;
    int          sel;
    logic [4:0]  rs1f;

    begin_test();
    for (int i = 0; i < 8; i++) begin
      issue(csr_instr(3'b010, rst_addrs[i], 5'd0, 5'(i + 1)), rand64(), 64'(i * 4));
    end
    end_test("reset_values");
    if (timed_out) return;

    begin_test();
    for (int i = 0; i < 60; i++) begin
      sel  = $urandom_range(5, 0);
      rs1f = ($urandom_range(3, 0) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
      issue(csr_instr((sel < 3) ? 3'(sel + 1) : 3'(sel + 2), pick_rmw_addr(), rs1f,
                      5'($urandom_range(31, 0))), rand64(), rand64());
      if ($urandom_range(2, 0) == 0) idle();
    end
    end_test("rmw_random");
    if (timed_out) return;

    begin_test();
    for (int i = 0; i < 16; i++) begin
      v        = rand64();
      v[16:13] = 4'(i); // every FS/XS combination
      issue(csr_instr(3'b001, csr_pkg::CSR_MSTATUS, 5'd9, 5'd0), v, rand64());
      issue(csr_instr(3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd4), rand64(), rand64());
    end
    issue(csr_instr(3'b001, csr_pkg::CSR_MSTATUS, 5'd9, 5'd0), csr_pkg::MSTATUS_RESET, 64'h100);
    end_test("mstatus_sd");
    if (timed_out) return;

    begin_test();
    issue(csr_instr(3'b001, csr_pkg::CSR_MTVEC, 5'd1, 5'd0), 64'h8000_1003, 64'h200);
    issue(csr_instr(3'b110, csr_pkg::CSR_MSTATUS, 5'd8, 5'd0), '0, 64'h204); // set MIE
    issue(INSTR_ECALL, '0, 64'h208);
    issue(csr_instr(3'b010, csr_pkg::CSR_MEPC, 5'd0, 5'd1), '0, 64'h8000_1000);
    issue(csr_instr(3'b010, csr_pkg::CSR_MCAUSE, 5'd0, 5'd2), '0, 64'h8000_1004);
    issue(csr_instr(3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd3), '0, 64'h8000_1008);
    issue(csr_instr(3'b001, csr_pkg::CSR_MEPC, 5'd1, 5'd0), 64'h20c, 64'h8000_100c);
    issue(32'h0010_0073, '0, 64'h8000_1010); // ebreak is a bubble here
    issue(INSTR_MRET, '0, 64'h8000_1014);
    issue(csr_instr(3'b010, csr_pkg::CSR_MSTATUS, 5'd0, 5'd3), '0, 64'h20c);
    end_test("ecall_mret");
    if (timed_out) return;

    begin_test();
    issue(csr_instr(3'b001, csr_pkg::CSR_MTVEC, 5'd1, 5'd0), 64'h4000_0100, 64'h300);
    issue(csr_instr(3'b001, csr_pkg::CSR_MIE, 5'd1, 5'd0), 64'h80, 64'h304);
    issue(csr_instr(3'b110, csr_pkg::CSR_MSTATUS, 5'd8, 5'd0), '0, 64'h308);
    drain();
    if (timed_out) return;
    set_timer(1'b1);
    issue(INSTR_NOP, '0, 64'h30c);
    issue(csr_instr(3'b010, csr_pkg::CSR_MCAUSE, 5'd0, 5'd5), '0, 64'h4000_0100);
    issue(csr_instr(3'b010, csr_pkg::CSR_MEPC, 5'd0, 5'd6), '0, 64'h4000_0104);
    issue(csr_instr(3'b010, csr_pkg::CSR_MIP, 5'd0, 5'd7), '0, 64'h4000_0108);
    issue(INSTR_MRET, '0, 64'h4000_010c);
    // MIE is back on so the timer takes over this csrrw
    issue(csr_instr(3'b001, csr_pkg::CSR_MSCRATCH, 5'd1, 5'd8), 64'hdead_beef_0bad_f00d,
          64'h30c);
    issue(csr_instr(3'b001, csr_pkg::CSR_MIE, 5'd0, 5'd0), '0, 64'h4000_0100);
    issue(csr_instr(3'b010, csr_pkg::CSR_MSCRATCH, 5'd0, 5'd9), '0, 64'h4000_0104);
    end_test("timer_irq");
    if (timed_out) return;
    set_timer(1'b0);

    begin_test();
    for (int k = 1; k < 6; k++) begin
      issue(csr_instr(3'b010, csr_pkg::CSR_MCYCLE, 5'd0, 5'd10), '0, 64'h400);
      repeat (k - 1) idle();
      issue(csr_instr(3'b010, csr_pkg::CSR_MCYCLE, 5'd0, 5'd11), '0, 64'h404);
    end
    end_test("mcycle_step");
  endtask

  initial begin
    void'($urandom(32'hd281_0c4d));
    clk         = 1'b0;
    rst         = 1'b1;
    i_valid     = 1'b0;
    i_instr     = '0;
    i_rs1_data  = '0;
    i_pc        = '0;
    i_irq_timer = 1'b0;
    m_mstatus   = csr_pkg::MSTATUS_RESET;
    m_mie       = '0;
    m_mtvec     = '0;
    m_mscratch  = '0;
    m_mepc      = '0;
    m_mcause    = '0;
    m_timer     = 1'b0;
    timed_out   = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    run_tests();

    $display("summary: %0d results checked, %0d mismatches", head, fails);
    if (fails == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
